/* design/puzzle_pkg.sv */
`default_nettype none

package puzzle_pkg;

	// 3x3 board, cells numbered row by row from the top left
	localparam int NUM_CELLS = 9;
	localparam int GRID_W = 3;

	typedef logic [3:0] tile_t;
	typedef logic [3:0] pos_t;

	// Tile value that marks the empty cell
	localparam tile_t BLANK_TILE = 4'd8;

	// Cell 0 sits in the low nibble
	// Goal board holds tile i in cell i
	typedef tile_t [NUM_CELLS-1:0] board_t;

	// One candidate digit, the direction the blank slides
	typedef enum logic [1:0] {
		DIR_UP    = 2'd0,
		DIR_DOWN  = 2'd1,
		DIR_RIGHT = 2'd2,
		DIR_LEFT  = 2'd3
	} dir_e;

	// Result of one blank move
	typedef struct packed {
		logic legal;
		pos_t target;
	} blank_step_t;

endpackage

`default_nettype wire

/* design/blank_mover.sv */
`default_nettype none

module blank_mover (
	input  puzzle_pkg::pos_t        blank_pos,
	input  puzzle_pkg::dir_e        dir,
	output puzzle_pkg::blank_step_t step
);

	localparam puzzle_pkg::pos_t W = puzzle_pkg::pos_t'(puzzle_pkg::GRID_W);
	localparam puzzle_pkg::pos_t LAST = puzzle_pkg::pos_t'(puzzle_pkg::GRID_W - 1);

	puzzle_pkg::pos_t row;
	puzzle_pkg::pos_t col;

	assign row = blank_pos / W;
	assign col = blank_pos % W;

	always_comb begin
		step.legal = 1'b0;
		step.target = blank_pos;
		case (dir)
			puzzle_pkg::DIR_UP: begin
				step.legal = (row != 4'd0);
				step.target = blank_pos - W;
			end
			puzzle_pkg::DIR_DOWN: begin
				step.legal = (row != LAST);
				step.target = blank_pos + W;
			end
			puzzle_pkg::DIR_RIGHT: begin
				step.legal = (col != LAST);
				step.target = blank_pos + 4'd1;
			end
			puzzle_pkg::DIR_LEFT: begin
				step.legal = (col != 4'd0);
				step.target = blank_pos - 4'd1;
			end
			default: step.legal = 1'b0;
		endcase
		// Off the board, keep the target on the blank
		if (!step.legal)
			step.target = blank_pos;
	end

endmodule

`default_nettype wire

/* design/move_counter.sv */
`default_nettype none

module move_counter #(
	parameter int MAX_DEPTH = 4
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   clear,
	input  logic                   next_step,
	input  logic                   next_cand,
	output puzzle_pkg::dir_e       dir,
	output logic                   steps_done,
	output logic                   exhausted,
	output logic [3:0]             cand_len,
	output logic [2*MAX_DEPTH-1:0] cand_moves
);

	logic [2*MAX_DEPTH-1:0] moves_q;
	logic [2*MAX_DEPTH-1:0] len_mask;
	logic [3:0]             len_q;
	logic [3:0]             step_q;
	logic [1:0]             digit_sel;
	logic                   wrap;

	// Ones over the digits in use, so the odometer wraps at the current length
	assign len_mask = ~({2*MAX_DEPTH{1'b1}} << (2*len_q));
	assign wrap = (moves_q == len_mask);

	assign steps_done = (step_q == len_q);
	assign exhausted = wrap && (len_q == 4'(MAX_DEPTH));

	always_comb begin
		digit_sel = 2'd0;
		for (int i = 0; i < MAX_DEPTH; i++) begin
			if (step_q == 4'(i))
				digit_sel = moves_q[2*i +: 2];
		end
	end

	assign dir = puzzle_pkg::dir_e'(digit_sel);

	always_ff @(posedge clk) begin
		if (!rst_n || clear) begin
			moves_q <= '0;
			len_q <= 4'd0;
			step_q <= 4'd0;
		end else if (next_cand) begin
			step_q <= 4'd0;
			if (wrap) begin
				len_q <= len_q + 4'd1;
				moves_q <= '0;
			end else begin
				moves_q <= moves_q + 1'b1;
			end
		end else if (next_step) begin
			step_q <= step_q + 4'd1;
		end
	end

	assign cand_len = len_q;
	assign cand_moves = moves_q;

endmodule

`default_nettype wire

/* design/board_reg.sv */
`default_nettype none

module board_reg (
	input  logic                    clk,
	input  logic                    rst_n,
	input  puzzle_pkg::board_t      start_board,
	input  logic                    load_start,
	input  logic                    load_work,
	input  logic                    apply,
	input  puzzle_pkg::blank_step_t step,
	output puzzle_pkg::pos_t        blank_pos,
	output logic                    solved
);

	puzzle_pkg::board_t start_q;
	puzzle_pkg::board_t work_q;
	puzzle_pkg::pos_t   blank_q;
	puzzle_pkg::pos_t   blank_init;

	// Blank cell of the captured start board
	always_comb begin
		blank_init = '0;
		for (int i = 0; i < puzzle_pkg::NUM_CELLS; i++) begin
			if (start_q[i] == puzzle_pkg::BLANK_TILE)
				blank_init = puzzle_pkg::pos_t'(i);
		end
	end

	always_ff @(posedge clk) begin
		if (load_start)
			start_q <= start_board;
		if (load_work) begin
			work_q <= start_q;
		end else if (apply) begin
			// Tile at the target slides into the old blank cell
			work_q[blank_q] <= work_q[step.target];
			work_q[step.target] <= puzzle_pkg::BLANK_TILE;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			blank_q <= '0;
		else if (load_work)
			blank_q <= blank_init;
		else if (apply)
			blank_q <= step.target;
	end

	always_comb begin
		solved = 1'b1;
		for (int i = 0; i < puzzle_pkg::NUM_CELLS; i++) begin
			if (work_q[i] != puzzle_pkg::tile_t'(i))
				solved = 1'b0;
		end
	end

	assign blank_pos = blank_q;

endmodule

`default_nettype wire

/* design/puzzle_ctrl.sv */
`default_nettype none

module puzzle_ctrl #(
	parameter int MAX_DEPTH = 4
) (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    start,
	input  puzzle_pkg::blank_step_t step,
	input  logic                    steps_done,
	input  logic                    exhausted,
	input  logic                    solved,
	output logic                    busy,
	output logic                    done,
	output logic                    found,
	output logic                    clear,
	output logic                    next_step,
	output logic                    next_cand,
	output logic                    load_start,
	output logic                    load_work,
	output logic                    apply,
	output logic                    latch_result
);

	typedef enum logic [2:0] {
		IDLE,
		LOAD,
		MOVE,
		CHECK,
		ADVANCE
	} state_e;

	state_e state_q;
	state_e state_d;
	logic   finish;

	// Candidate length travels in 4 bits
	if (MAX_DEPTH < 1 || MAX_DEPTH > 8) begin : g_depth_check
		$error("puzzle_ctrl: MAX_DEPTH must lie in 1..8");
	end

	always_comb begin
		state_d = state_q;
		clear = 1'b0;
		next_step = 1'b0;
		next_cand = 1'b0;
		load_start = 1'b0;
		load_work = 1'b0;
		apply = 1'b0;
		latch_result = 1'b0;
		finish = 1'b0;
		case (state_q)
			IDLE: begin
				if (start) begin
					load_start = 1'b1;
					clear = 1'b1;
					state_d = LOAD;
				end
			end
			LOAD: begin
				load_work = 1'b1;
				state_d = MOVE;
			end
			MOVE: begin
				// Replay ends at the last digit or at the first illegal move
				if (steps_done) begin
					state_d = CHECK;
				end else if (!step.legal) begin
					state_d = ADVANCE;
				end else begin
					apply = 1'b1;
					next_step = 1'b1;
				end
			end
			CHECK: begin
				if (solved) begin
					latch_result = 1'b1;
					finish = 1'b1;
					state_d = IDLE;
				end else begin
					state_d = ADVANCE;
				end
			end
			ADVANCE: begin
				if (exhausted) begin
					finish = 1'b1;
					state_d = IDLE;
				end else begin
					next_cand = 1'b1;
					state_d = LOAD;
				end
			end
			default: state_d = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state_q <= IDLE;
			done <= 1'b0;
			found <= 1'b0;
		end else begin
			state_q <= state_d;
			done <= finish;
			if (load_start)
				found <= 1'b0;
			else if (latch_result)
				found <= 1'b1;
		end
	end

	assign busy = (state_q != IDLE);

endmodule

`default_nettype wire

/* design/puzzle_solver.sv */
`default_nettype none

module puzzle_solver #(
	parameter int MAX_DEPTH = 4
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   start,
	input  puzzle_pkg::board_t     start_board,
	output logic                   busy,
	output logic                   done,
	output logic                   found,
	output logic [3:0]             sol_len,
	output logic [2*MAX_DEPTH-1:0] sol_moves
);

	puzzle_pkg::blank_step_t step;
	puzzle_pkg::dir_e        dir;
	puzzle_pkg::pos_t        blank_pos;
	logic                    steps_done;
	logic                    exhausted;
	logic                    solved;
	logic                    clear;
	logic                    next_step;
	logic                    next_cand;
	logic                    load_start;
	logic                    load_work;
	logic                    apply;
	logic                    latch_result;
	logic [3:0]              cand_len;
	logic [2*MAX_DEPTH-1:0]  cand_moves;

	puzzle_ctrl #(
		.MAX_DEPTH(MAX_DEPTH)
	) ctrl_inst (
		.clk(clk),
		.rst_n(rst_n),
		.start(start),
		.step(step),
		.steps_done(steps_done),
		.exhausted(exhausted),
		.solved(solved),
		.busy(busy),
		.done(done),
		.found(found),
		.clear(clear),
		.next_step(next_step),
		.next_cand(next_cand),
		.load_start(load_start),
		.load_work(load_work),
		.apply(apply),
		.latch_result(latch_result)
	);

	move_counter #(
		.MAX_DEPTH(MAX_DEPTH)
	) counter_inst (
		.clk(clk),
		.rst_n(rst_n),
		.clear(clear),
		.next_step(next_step),
		.next_cand(next_cand),
		.dir(dir),
		.steps_done(steps_done),
		.exhausted(exhausted),
		.cand_len(cand_len),
		.cand_moves(cand_moves)
	);

	blank_mover mover_inst (
		.blank_pos(blank_pos),
		.dir(dir),
		.step(step)
	);

	board_reg board_inst (
		.clk(clk),
		.rst_n(rst_n),
		.start_board(start_board),
		.load_start(load_start),
		.load_work(load_work),
		.apply(apply),
		.step(step),
		.blank_pos(blank_pos),
		.solved(solved)
	);

	// Cleared with found on start, captured on a solve
	always_ff @(posedge clk) begin
		if (!rst_n || load_start) begin
			sol_len <= 4'd0;
			sol_moves <= '0;
		end else if (latch_result) begin
			sol_len <= cand_len;
			sol_moves <= cand_moves;
		end
	end

endmodule

`default_nettype wire

/* tests/tb_clock_gen.sv */
`default_nettype none

module tb_clock_gen #(
	parameter int PERIOD = 100
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

endmodule

`default_nettype wire

/* tests/puzzle_cases.svh */
`ifndef PUZZLE_CASES_SVH
`define PUZZLE_CASES_SVH

// Columns: start board, restart flag, board of the ignored start, found, length, moves
// Boards run from cell 8 in the top nibble down to cell 0, blank is tile 8
// Move digit i sits at bits 2i+1:2i, up 0, down 1, right 2, left 3
typedef struct packed {
	puzzle_pkg::board_t board;
	logic               restart;
	puzzle_pkg::board_t other;
	logic               found;
	logic [3:0]         len;
	logic [7:0]         moves;
} solver_case_t;

localparam int NUM_CASES = 9;

function automatic solver_case_t case_row(input int idx);
	solver_case_t row;
	case (idx)
		0: row = '{36'h8_7654_3210, 1'b0, 36'h0, 1'b1, 4'd0, 8'h00};
		1: row = '{36'h5_7684_3210, 1'b0, 36'h0, 1'b1, 4'd1, 8'h01};
		2: row = '{36'h7_8654_3210, 1'b0, 36'h0, 1'b1, 4'd1, 8'h02};
		// right, down
		3: row = '{36'h5_7648_3210, 1'b0, 36'h0, 1'b1, 4'd2, 8'h06};
		// down, right
		4: row = '{36'h7_4658_3210, 1'b0, 36'h0, 1'b1, 4'd2, 8'h09};
		// up, right, down
		5: row = '{36'h5_8647_3210, 1'b0, 36'h0, 1'b1, 4'd3, 8'h18};
		// left, down, right, right
		6: row = '{36'h7_6358_4210, 1'b0, 36'h0, 1'b1, 4'd4, 8'ha7};
		// Tiles 0 and 1 swapped, odd parity
		7: row = '{36'h8_7654_3201, 1'b0, 36'h0, 1'b0, 4'd0, 8'h00};
		// Goal board offered while busy must not be taken
		8: row = '{36'h7_6358_4210, 1'b1, 36'h8_7654_3210, 1'b1, 4'd4, 8'ha7};
		default: row = '0;
	endcase
	return row;
endfunction

`endif

/* tests/puzzle_solver_tb.sv */
`default_nettype none

module puzzle_solver_tb;

	localparam int MAX_DEPTH = 4;
	localparam int CLK_PERIOD = 100;
	localparam int RESET_CYCLES = 10;
	localparam int unsigned SEED = 32'h7f0b_6d77;

	`include "puzzle_cases.svh"

	logic                   clk;
	logic                   rst_n;
	logic                   start;
	puzzle_pkg::board_t     start_board;
	logic                   busy;
	logic                   done;
	logic                   found;
	logic [3:0]             sol_len;
	logic [2*MAX_DEPTH-1:0] sol_moves;
	int                     checks;
	int                     errors;

	tb_clock_gen #(.PERIOD(CLK_PERIOD)) clock_inst (.clk(clk));

	puzzle_solver #(.MAX_DEPTH(MAX_DEPTH)) puzzle_solver_inst (
		.clk(clk),
		.rst_n(rst_n),
		.start(start),
		.start_board(start_board),
		.busy(busy),
		.done(done),
		.found(found),
		.sol_len(sol_len),
		.sol_moves(sol_moves)
	);

	// Every candidate up to depth, each LOAD, len+1 MOVE, CHECK and ADVANCE
	function automatic int case_budget(input int depth);
		int cycles;
		int count;
		cycles = 0;
		count = 1;
		for (int len = 0; len <= depth; len++) begin
			cycles += count * (len + 4);
			count *= 4;
		end
		return cycles;
	endfunction

	task automatic expect_equal(input string what, input logic [35:0] got, input logic [35:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("** Error [%0t] %s: got %0h, expected %0h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic run_case(input int idx);
		solver_case_t row;
		int           errors_before;
		row = case_row(idx);
		errors_before = errors;
		repeat ($urandom_range(6, 0)) @(negedge clk);
		start = 1'b1;
		start_board = row.board;
		@(negedge clk);
		start = 1'b0;
		expect_equal("busy one cycle after start", busy, 1'b1);
		if (row.restart) begin
			start = 1'b1;
			start_board = row.other;
			@(negedge clk);
			start = 1'b0;
			expect_equal("busy after ignored start", busy, 1'b1);
		end
		while (!done)
			@(negedge clk);
		expect_equal("busy at done", busy, 1'b0);
		expect_equal("found", found, row.found);
		expect_equal("sol_len", sol_len, row.len);
		expect_equal("sol_moves", sol_moves, row.moves);
		@(negedge clk);
		expect_equal("done after one cycle", done, 1'b0);
		expect_equal("result held", {found, sol_len, sol_moves}, {row.found, row.len, row.moves});
		$display("case %0d board %h: found %0b len %0d moves %h %s", idx, row.board,
			found, sol_len, sol_moves, (errors == errors_before) ? "ok" : "mismatch");
	endtask

	initial begin
		void'($urandom(SEED));
		rst_n = 1'b0;
		start = 1'b0;
		start_board = '0;
		checks = 0;
		errors = 0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		expect_equal("reset state", {busy, done, found, sol_len, sol_moves}, '0);
		$display("reset state: %s", (errors == 0) ? "ok" : "mismatch");
		for (int i = 0; i < NUM_CASES; i++)
			run_case(i);
		$display("Summary: %0d tests, %0d checks, %0d errors", NUM_CASES + 1, checks, errors);
		if (errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

	// Worst case per run, plus idle gaps, extra start pulse and reset
	initial begin
		int budget;
		budget = RESET_CYCLES + 2 + NUM_CASES * (case_budget(MAX_DEPTH) + 16) + 50;
		#(budget * CLK_PERIOD);
		$display("Timeout: the solver never signalled done within %0d clock cycles", budget);
		$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire

/* compile.f */
+incdir+tests
design/puzzle_pkg.sv
design/blank_mover.sv
design/move_counter.sv
design/board_reg.sv
design/puzzle_ctrl.sv
design/puzzle_solver.sv
tests/tb_clock_gen.sv
tests/puzzle_solver_tb.sv

/* Bender.yml */
package:
  name: puzzle_solver

sources:
  - design/puzzle_pkg.sv
  - design/blank_mover.sv
  - design/move_counter.sv
  - design/board_reg.sv
  - design/puzzle_ctrl.sv
  - design/puzzle_solver.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_clock_gen.sv
      - tests/puzzle_solver_tb.sv
